//--- common/la_consts.svh
//////////////////////////////////////////////////////////////////////
// logic analyzer constants
// widths of samples, counters and timestamps, and the register map
//////////////////////////////////////////////////////////////////////

`ifndef LA_CONSTS_SVH
`define LA_CONSTS_SVH

// data widths
`define LA_DW   8
`define LA_CW   16
`define LA_DCW  16
`define LA_TW   64
// trigger sources: pattern, software, 2x external
`define LA_TN   4
// wishbone data and decoded address widths
`define LA_BW   32
`define LA_AW   7

// register offsets
`define LA_ADR_CTL     7'h00
`define LA_ADR_TSEL    7'h08
`define LA_ADR_PRE     7'h10
`define LA_ADR_PST     7'h14
`define LA_ADR_SPRE    7'h18
`define LA_ADR_SPST    7'h1c
`define LA_ADR_TACQ_L  7'h20
`define LA_ADR_TACQ_H  7'h24
`define LA_ADR_TTRG_L  7'h28
`define LA_ADR_TTRG_H  7'h2c
`define LA_ADR_TSTP_L  7'h30
`define LA_ADR_TSTP_H  7'h34
// pattern trigger
`define LA_ADR_OVAL    7'h40
`define LA_ADR_OMSK    7'h44
`define LA_ADR_CVAL    7'h48
`define LA_ADR_CMSK    7'h4c
// decimation
`define LA_ADR_DEC     7'h50

`endif

//--- common/la_pkg.sv
//////////////////////////////////////////////////////////////////////
// logic analyzer types
// sample, configuration, control, status and wishbone structs
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "la_consts.svh"

package la_pkg;

  typedef logic [`LA_DW-1:0] smp_t;

  // register block configuration
  typedef struct packed {
    logic [`LA_TN-1:0]  tsel;
    logic [`LA_CW-1:0]  pre;
    logic [`LA_CW-1:0]  pst;
    smp_t               old_val;
    smp_t               old_msk;
    smp_t               cur_val;
    smp_t               cur_msk;
    logic [`LA_DCW-1:0] dec;
  } cfg_t;

  // one-cycle pulses from control register writes
  typedef struct packed {
    logic rst;
    logic acq;
    logic stp;
    logic swt;
  } ctl_t;

  // acquisition status
  typedef struct packed {
    logic              acq;
    logic              trg;
    logic [`LA_CW-1:0] spre;
    logic [`LA_CW-1:0] spst;
    logic [`LA_TW-1:0] tacq;
    logic [`LA_TW-1:0] ttrg;
    logic [`LA_TW-1:0] tstp;
  } sts_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [`LA_BW-1:0] adr;
    logic [`LA_BW-1:0] dat_w;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic              ack;
    logic [`LA_BW-1:0] dat_r;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- rtl/str_dec.sv
//////////////////////////////////////////////////////////////////////
// stream decimator
// forwards one of every (dec + 1) input transfers, registered output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module str_dec #(
  parameter type         dat_t = logic [7:0],
  parameter int unsigned DCW   = 16
) (
  input  logic           bus,
  input  logic           reset,
  // restart of the decimation count
  input  logic           clr,
  input  logic [DCW-1:0] dec,
  // input stream
  input  dat_t           sti_dat,
  input  logic           sti_vld,
  output logic           sti_rdy,
  // output stream
  output dat_t           sto_dat,
  output logic           sto_vld,
  input  logic           sto_rdy
);

  logic [DCW-1:0] cnt;
  logic           sti_trn;
  logic           keep;

  // output reg takes data when empty or draining
  assign sti_rdy = ~sto_vld | sto_rdy;
  assign sti_trn = sti_vld & sti_rdy;
  // index modulo (dec + 1) is zero
  assign keep    = (cnt == '0);

  // transfer index, wraps after dec skipped samples
  always_ff @(posedge bus) begin
    if (reset || clr) begin
      cnt <= '0;
    end else if (sti_trn) begin
      // >= covers dec lowered mid-count
      cnt <= (cnt >= dec) ? '0 : cnt + 1'b1;
    end
  end

  always_ff @(posedge bus) begin
    if (reset || clr) begin
      sto_vld <= 1'b0;
    end else if (sti_rdy) begin
      sto_vld <= sti_vld & keep;
    end
  end

  // payload
  always_ff @(posedge bus) begin
    if (sti_trn && keep) begin
      sto_dat <= sti_dat;
    end
  end

  // stalled output holds its data
  a_sto_hold: assert property (@(posedge bus) disable iff (reset)
    sto_vld && !sto_rdy |=> $stable(sto_dat));

endmodule

`default_nettype wire

//--- la/la_regs.sv
//////////////////////////////////////////////////////////////////////
// logic analyzer register block
// wishbone classic slave, holds configuration, issues control pulses
// and reads back status
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "la_consts.svh"

module la_regs (
  input  logic            bus,
  input  logic            reset,
  // wishbone
  input  la_pkg::wb_req_t wb_req,
  output la_pkg::wb_rsp_t wb_rsp,
  // to datapath
  output la_pkg::cfg_t    cfg,
  output la_pkg::ctl_t    ctl,
  input  la_pkg::sts_t    sts
);

  logic              ack;
  logic [`LA_BW-1:0] dat_r;
  logic              acc;
  logic              wr;
  logic [`LA_AW-1:0] adr;
  logic [`LA_BW-1:0] dat_w;

  assign adr   = wb_req.adr[`LA_AW-1:0];
  assign dat_w = wb_req.dat_w;
  // new access, ack low
  assign acc   = wb_req.cyc & wb_req.stb & ~ack;
  assign wr    = acc & wb_req.we;

  assign wb_rsp = '{ack: ack, dat_r: dat_r};

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  // one cycle ack, so every access takes two cycles
  always_ff @(posedge bus) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= acc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // writes
  //////////////////////////////////////////////////////////////////////

  // config lands on the ack cycle
  always_ff @(posedge bus) begin
    if (reset) begin
      cfg <= '0;
    end else if (wr) begin
      case (adr)
        `LA_ADR_TSEL: cfg.tsel    <= dat_w[`LA_TN-1:0];
        `LA_ADR_PRE:  cfg.pre     <= dat_w[`LA_CW-1:0];
        `LA_ADR_PST:  cfg.pst     <= dat_w[`LA_CW-1:0];
        `LA_ADR_OVAL: cfg.old_val <= dat_w[`LA_DW-1:0];
        `LA_ADR_OMSK: cfg.old_msk <= dat_w[`LA_DW-1:0];
        `LA_ADR_CVAL: cfg.cur_val <= dat_w[`LA_DW-1:0];
        `LA_ADR_CMSK: cfg.cur_msk <= dat_w[`LA_DW-1:0];
        `LA_ADR_DEC:  cfg.dec     <= dat_w[`LA_DCW-1:0];
        default: ;
      endcase
    end
  end

  // control pulses, high only on the ack cycle
  always_ff @(posedge bus) begin
    if (reset) begin
      ctl <= '0;
    end else begin
      ctl <= '0;
      if (wr && adr == `LA_ADR_CTL) begin
        ctl.rst <= dat_w[0];
        ctl.acq <= dat_w[1];
        ctl.stp <= dat_w[2];
        // software trigger
        ctl.swt <= dat_w[3];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reads
  //////////////////////////////////////////////////////////////////////

  // registered, valid with ack
  always_ff @(posedge bus) begin
    if (acc) begin
      case (adr)
        `LA_ADR_CTL:    dat_r <= `LA_BW'({sts.trg, sts.acq, 1'b0});
        `LA_ADR_TSEL:   dat_r <= `LA_BW'(cfg.tsel);
        `LA_ADR_PRE:    dat_r <= `LA_BW'(cfg.pre);
        `LA_ADR_PST:    dat_r <= `LA_BW'(cfg.pst);
        `LA_ADR_SPRE:   dat_r <= `LA_BW'(sts.spre);
        `LA_ADR_SPST:   dat_r <= `LA_BW'(sts.spst);
        // timestamps in two words
        `LA_ADR_TACQ_L: dat_r <= sts.tacq[31:0];
        `LA_ADR_TACQ_H: dat_r <= sts.tacq[`LA_TW-1:32];
        `LA_ADR_TTRG_L: dat_r <= sts.ttrg[31:0];
        `LA_ADR_TTRG_H: dat_r <= sts.ttrg[`LA_TW-1:32];
        `LA_ADR_TSTP_L: dat_r <= sts.tstp[31:0];
        `LA_ADR_TSTP_H: dat_r <= sts.tstp[`LA_TW-1:32];
        `LA_ADR_OVAL:   dat_r <= `LA_BW'(cfg.old_val);
        `LA_ADR_OMSK:   dat_r <= `LA_BW'(cfg.old_msk);
        `LA_ADR_CVAL:   dat_r <= `LA_BW'(cfg.cur_val);
        `LA_ADR_CMSK:   dat_r <= `LA_BW'(cfg.cur_msk);
        `LA_ADR_DEC:    dat_r <= `LA_BW'(cfg.dec);
        default:        dat_r <= '0;
      endcase
    end
  end

  // back-to-back transfers still leave a gap in ack
  a_ack_single: assert property (@(posedge bus) disable iff (reset)
    wb_rsp.ack |=> !wb_rsp.ack);

endmodule

`default_nettype wire

//--- la/la_trigger.sv
//////////////////////////////////////////////////////////////////////
// pattern trigger
// matches previous and current decimated samples under masks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module la_trigger (
  input  logic         bus,
  input  logic         reset,
  input  logic         clr,
  input  la_pkg::cfg_t cfg,
  // monitored stream
  input  la_pkg::smp_t dat,
  input  logic         trn,
  output logic         trg
);

  la_pkg::smp_t old_dat;
  logic         old_vld;
  logic         old_hit;
  logic         cur_hit;

  // no previous sample after clear
  always_ff @(posedge bus) begin
    if (reset || clr) begin
      old_vld <= 1'b0;
    end else if (trn) begin
      old_vld <= 1'b1;
    end
  end

  // last transferred sample
  always_ff @(posedge bus) begin
    if (trn) begin
      old_dat <= dat;
    end
  end

  // masked bits only
  assign old_hit = ((old_dat ^ cfg.old_val) & cfg.old_msk) == '0;
  assign cur_hit = ((dat ^ cfg.cur_val) & cfg.cur_msk) == '0;

  // fires in the matching transfer cycle
  assign trg = trn & old_vld & old_hit & cur_hit;

endmodule

`default_nettype wire

//--- la/la_acq.sv
//////////////////////////////////////////////////////////////////////
// acquisition controller
// pre-trigger window, armed wait, post-trigger window, output stream
// and timestamps for start, trigger and stop
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "la_consts.svh"

module la_acq (
  input  logic              bus,
  input  logic              reset,
  input  la_pkg::ctl_t      ctl,
  input  la_pkg::cfg_t      cfg,
  // trigger sources and time
  input  logic [`LA_TN-1:0] trg,
  input  logic [`LA_TW-1:0] cts,
  // decimated stream in
  input  la_pkg::smp_t      sti_dat,
  input  logic              sti_vld,
  output logic              sti_rdy,
  // captured stream out
  output la_pkg::smp_t      sto_dat,
  output logic              sto_vld,
  output logic              sto_lst,
  input  logic              sto_rdy,
  output la_pkg::sts_t      sts
);

  logic              acq_r;
  logic              trg_r;
  logic [`LA_CW-1:0] spre;
  logic [`LA_CW-1:0] spst;
  logic [`LA_TW-1:0] tacq;
  logic [`LA_TW-1:0] ttrg;
  logic [`LA_TW-1:0] tstp;
  logic              sti_trn;
  logic              fwd;
  logic              pre_ph;
  logic              armed;
  logic              hit;
  logic              last;
  logic [`LA_CW-1:0] spst_nxt;

  // back-pressure from sto reaches the decimator
  assign sti_rdy  = ~sto_vld | sto_rdy;
  assign sti_trn  = sti_vld & sti_rdy;
  // run still forwarding this cycle
  assign fwd      = acq_r & ~ctl.stp;

  // phases
  assign pre_ph   = acq_r & ~trg_r & (spre < cfg.pre);
  assign armed    = acq_r & ~trg_r & (spre >= cfg.pre);
  assign hit      = armed & |(trg & cfg.tsel);

  // post window, trigger sample not counted
  assign spst_nxt = spst + 1'b1;
  assign last     = fwd & trg_r & sti_trn & (spst_nxt >= cfg.pst);

  assign sts = '{acq: acq_r, trg: trg_r, spre: spre, spst: spst,
                 tacq: tacq, ttrg: ttrg, tstp: tstp};

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || ctl.rst) begin
      acq_r <= 1'b0;
      trg_r <= 1'b0;
      spre  <= '0;
      spst  <= '0;
      tacq  <= '0;
      ttrg  <= '0;
      tstp  <= '0;
    end else if (ctl.acq) begin
      // start or restart
      acq_r <= 1'b1;
      trg_r <= 1'b0;
      spre  <= '0;
      spst  <= '0;
      tacq  <= cts;
    end else if (acq_r) begin
      if (ctl.stp) begin
        // early stop, trigger status kept as is
        acq_r <= 1'b0;
        tstp  <= cts;
      end else begin
        if (pre_ph && sti_trn) begin
          spre <= spre + 1'b1;
        end
        if (hit) begin
          trg_r <= 1'b1;
          ttrg  <= cts;
          // empty post window ends the run here
          if (cfg.pst == '0) begin
            acq_r <= 1'b0;
            tstp  <= cts;
          end
        end
        if (trg_r && sti_trn) begin
          spst <= spst_nxt;
          if (last) begin
            acq_r <= 1'b0;
            tstp  <= cts;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (reset || ctl.rst) begin
      sto_vld <= 1'b0;
      sto_lst <= 1'b0;
    end else if (sti_rdy) begin
      sto_vld <= sti_vld & fwd;
      sto_lst <= last;
    end
  end

  always_ff @(posedge bus) begin
    if (sti_trn) begin
      sto_dat <= sti_dat;
    end
  end

  // trigger only latched from an active run
  a_trg_in_run: assert property (@(posedge bus) disable iff (reset)
    $rose(trg_r) |-> $past(acq_r));

endmodule

`default_nettype wire

//--- la/la_top.sv
//////////////////////////////////////////////////////////////////////
// logic analyzer top
// register block, decimator, pattern trigger, acquisition
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "la_consts.svh"

module la_top (
  input  logic              bus,
  input  logic              reset,
  // register port
  input  la_pkg::wb_req_t   wb_req,
  output la_pkg::wb_rsp_t   wb_rsp,
  // sample stream
  input  la_pkg::smp_t      sti_dat,
  input  logic              sti_vld,
  output logic              sti_rdy,
  // captured stream
  output la_pkg::smp_t      sto_dat,
  output logic              sto_vld,
  output logic              sto_lst,
  input  logic              sto_rdy,
  // time and triggers
  input  logic [`LA_TW-1:0] cts,
  input  logic [1:0]        trg_ext,
  output logic              trg_out
);

  la_pkg::cfg_t      cfg;
  la_pkg::ctl_t      ctl;
  la_pkg::sts_t      sts;
  // decimated stream
  la_pkg::smp_t      dec_dat;
  logic              dec_vld;
  logic              dec_rdy;
  // external, software, pattern
  logic [`LA_TN-1:0] trg_vec;

  assign trg_vec = {trg_ext, ctl.swt, trg_out};

  la_regs regs_i (
    .bus    (bus),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .cfg    (cfg),
    .ctl    (ctl),
    .sts    (sts)
  );

  str_dec #(
    .dat_t (la_pkg::smp_t),
    .DCW   (`LA_DCW)
  ) dec_i (
    .bus     (bus),
    .reset   (reset),
    .clr     (ctl.rst),
    .dec     (cfg.dec),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .sti_rdy (sti_rdy),
    .sto_dat (dec_dat),
    .sto_vld (dec_vld),
    .sto_rdy (dec_rdy)
  );

  // watches decimated transfers
  la_trigger trigger_i (
    .bus   (bus),
    .reset (reset),
    .clr   (ctl.rst),
    .cfg   (cfg),
    .dat   (dec_dat),
    .trn   (dec_vld & dec_rdy),
    .trg   (trg_out)
  );

  la_acq acq_i (
    .bus     (bus),
    .reset   (reset),
    .ctl     (ctl),
    .cfg     (cfg),
    .trg     (trg_vec),
    .cts     (cts),
    .sti_dat (dec_dat),
    .sti_vld (dec_vld),
    .sti_rdy (dec_rdy),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_lst (sto_lst),
    .sto_rdy (sto_rdy),
    .sts     (sts)
  );

endmodule

`default_nettype wire

//--- tests/la_tb.sv
//////////////////////////////////////////////////////////////////////
// logic analyzer testbench
// runs register, stream and trigger commands from a vector file and
// checks the captured stream against a sample-level model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "la_consts.svh"

module la_tb;

  localparam int TMO = 200;

  logic              bus;
  logic              reset;
  la_pkg::wb_req_t   wb_req;
  la_pkg::wb_rsp_t   wb_rsp;
  la_pkg::smp_t      sti_dat;
  logic              sti_vld;
  logic              sti_rdy;
  la_pkg::smp_t      sto_dat;
  logic              sto_vld;
  logic              sto_lst;
  logic              sto_rdy;
  logic [`LA_TW-1:0] cts;
  logic [1:0]        trg_ext;
  logic              trg_out;

  logic [31:0]       lfsr;
  string             tname;
  int                val_errs;
  int                tmo_errs;
  int                seq_errs;
  logic              bp_on;
  logic [7:0]        bp_rnd;
  // expected sto sequence
  la_pkg::smp_t      exp_dat[$];
  logic              exp_lst[$];
  int                trg_got;
  int                trg_exp;
  // model state
  la_pkg::cfg_t      mcfg;
  logic              m_run;
  logic              m_trg;
  logic              m_prv_vld;
  la_pkg::smp_t      m_prv;
  int                m_spre;
  int                m_spst;
  int                m_idx;
  logic [`LA_TW-1:0] t_issue;

  la_top dut_i (
    .bus     (bus),
    .reset   (reset),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .sti_dat (sti_dat),
    .sti_vld (sti_vld),
    .sti_rdy (sti_rdy),
    .sto_dat (sto_dat),
    .sto_vld (sto_vld),
    .sto_lst (sto_lst),
    .sto_rdy (sto_rdy),
    .cts     (cts),
    .trg_ext (trg_ext),
    .trg_out (trg_out)
  );

  initial begin
    bus = 1'b0;
    forever #4 bus = ~bus;
  end

  // cycle count doubles as timestamp source
  always @(posedge bus) begin
    cts <= cts + 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // checks and random bits
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s %s expected %h actual %h", tname, what, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_smp(input string what, input la_pkg::smp_t exp, input la_pkg::smp_t act);
    if (exp !== act) begin
      $display("ERROR %s %s expected %h actual %h", tname, what, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERROR %s %s expected %b actual %b", tname, what, exp, act);
      val_errs++;
    end
  endtask

  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic draw_bits(input int n, output logic [7:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[6:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////////////////////////

  // drawn on the falling edge apart from the sample draws
  always @(negedge bus) begin
    if (bp_on) begin
      draw_bits(1, bp_rnd);
    end
  end

  always @(posedge bus) begin
    sto_rdy <= bp_on ? bp_rnd[0] : 1'b1;
  end

  // sto transfer happens on the next rising edge
  always @(negedge bus) begin
    if (!reset && sto_vld && sto_rdy) begin
      if (exp_dat.size() == 0) begin
        $display("unexpected sample %h on sto in test %s", sto_dat, tname);
        seq_errs++;
      end else begin
        check_smp("sto_dat", exp_dat.pop_front(), sto_dat);
        check_bit("sto_lst", exp_lst.pop_front(), sto_lst);
      end
    end
    if (!reset && trg_out) begin
      trg_got++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // model
  //////////////////////////////////////////////////////////////////////

  // one kept sample through trigger and acquisition rules
  task automatic model_smp(input la_pkg::smp_t d);
    logic hit;
    logic lst;
    // every masked bit equals its value bit
    hit = m_prv_vld && ((m_prv & mcfg.old_msk) == (mcfg.old_val & mcfg.old_msk)) &&
          ((d & mcfg.cur_msk) == (mcfg.cur_val & mcfg.cur_msk));
    lst = 1'b0;
    if (hit) begin
      trg_exp++;
    end
    m_prv     = d;
    m_prv_vld = 1'b1;
    if (m_run) begin
      if (m_spre < mcfg.pre) begin
        m_spre++;
      end else if (!m_trg) begin
        // trigger sample itself is not counted
        m_trg = hit & mcfg.tsel[0];
      end else begin
        m_spst++;
        if (m_spst >= mcfg.pst) begin
          lst   = 1'b1;
          m_run = 1'b0;
        end
      end
      exp_dat.push_back(d);
      exp_lst.push_back(lst);
    end
  endtask

  task automatic model_ctl(input logic [31:0] d);
    if (d[0]) begin
      m_run     = 1'b0;
      m_trg     = 1'b0;
      m_spre    = 0;
      m_spst    = 0;
      m_idx     = 0;
      m_prv_vld = 1'b0;
    end else if (d[1]) begin
      m_run  = 1'b1;
      m_trg  = 1'b0;
      m_spre = 0;
      m_spst = 0;
    end else if (m_run && d[2]) begin
      m_run = 1'b0;
    end else if (m_run && d[3] && mcfg.tsel[1] && !m_trg && m_spre >= mcfg.pre) begin
      m_trg = 1'b1;
    end
  endtask

  task automatic model_write(input logic [31:0] a, input logic [31:0] d);
    case (a[`LA_AW-1:0])
      `LA_ADR_CTL:  model_ctl(d);
      `LA_ADR_TSEL: mcfg.tsel    = d[`LA_TN-1:0];
      `LA_ADR_PRE:  mcfg.pre     = d[`LA_CW-1:0];
      `LA_ADR_PST:  mcfg.pst     = d[`LA_CW-1:0];
      `LA_ADR_OVAL: mcfg.old_val = d[`LA_DW-1:0];
      `LA_ADR_OMSK: mcfg.old_msk = d[`LA_DW-1:0];
      `LA_ADR_CVAL: mcfg.cur_val = d[`LA_DW-1:0];
      `LA_ADR_CMSK: mcfg.cur_msk = d[`LA_DW-1:0];
      `LA_ADR_DEC:  mcfg.dec     = d[`LA_DCW-1:0];
      default: ;
    endcase
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus and stream drivers
  //////////////////////////////////////////////////////////////////////

  task automatic wb_access(input logic we, input logic [31:0] a, input logic [31:0] d,
                           output logic [31:0] r);
    int w;
    @(posedge bus);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: a, dat_w: d};
    w = 0;
    do begin
      @(negedge bus);
      w++;
    end while (!wb_rsp.ack && w < TMO);
    r = wb_rsp.dat_r;
    if (!wb_rsp.ack) begin
      $display("no ack for access to %h in test %s", a, tname);
      tmo_errs++;
    end
    check_word("ack latency", 2, w);
    @(posedge bus);
    wb_req <= '0;
    // single cycle ack
    @(negedge bus);
    check_bit("ack after access", 1'b0, wb_rsp.ack);
  endtask

  // wait until the expected sto sequence has been consumed
  task automatic drain();
    int w;
    w = 0;
    while (exp_dat.size() != 0 && w < TMO * 4) begin
      @(posedge bus);
      w++;
    end
    if (exp_dat.size() != 0) begin
      $display("%0d samples never appeared on sto in test %s", exp_dat.size(), tname);
      tmo_errs++;
      exp_dat.delete();
      exp_lst.delete();
    end
    repeat (4) @(posedge bus);
  endtask

  task automatic send_smps(input int n);
    logic [7:0] v;
    int         i;
    int         w;
    int         per;
    per = mcfg.dec + 1;
    for (i = 0; i < n; i++) begin
      @(posedge bus);
      draw_bits(8, v);
      sti_dat <= v;
      sti_vld <= 1'b1;
      w = 0;
      do begin
        @(negedge bus);
        w++;
      end while (!sti_rdy && w < TMO);
      if (!sti_rdy) begin
        $display("sti_rdy stuck low in test %s", tname);
        tmo_errs++;
      end else begin
        // decimator keeps the indices that are multiples of dec + 1
        if (m_idx % per == 0) begin
          model_smp(v);
        end
        m_idx++;
      end
    end
    @(posedge bus);
    sti_vld <= 1'b0;
    drain();
  endtask

  task automatic check_stamps();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] st;
    logic [63:0] ta;
    logic [63:0] tt;
    logic [63:0] tp;
    wb_access(1'b0, `LA_ADR_TACQ_L, '0, lo);
    wb_access(1'b0, `LA_ADR_TACQ_H, '0, hi);
    ta = {hi, lo};
    wb_access(1'b0, `LA_ADR_TTRG_L, '0, lo);
    wb_access(1'b0, `LA_ADR_TTRG_H, '0, hi);
    tt = {hi, lo};
    wb_access(1'b0, `LA_ADR_TSTP_L, '0, lo);
    wb_access(1'b0, `LA_ADR_TSTP_H, '0, hi);
    tp = {hi, lo};
    wb_access(1'b0, `LA_ADR_CTL, '0, st);
    check_bit("tacq not before start", 1'b1, ta >= t_issue);
    check_bit("tstp not before tacq", 1'b1, tp >= ta);
    check_bit("tstp not after now", 1'b1, tp <= cts);
    // ttrg only meaningful for a triggered run
    if (st[2]) begin
      check_bit("ttrg not before tacq", 1'b1, tt >= ta);
      check_bit("tstp not before ttrg", 1'b1, tp >= tt);
    end
  endtask

  task automatic end_test();
    drain();
    check_word("trg_out pulses", trg_exp, trg_got);
    @(posedge bus);
    bp_on <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // command loop
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          r;
    int          n;
    string       cmd;
    string       line;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] rd;
    lfsr      = 32'h6207eda3;
    tname     = "none";
    val_errs  = 0;
    tmo_errs  = 0;
    seq_errs  = 0;
    trg_got   = 0;
    trg_exp   = 0;
    bp_on     = 1'b0;
    bp_rnd    = 8'h01;
    mcfg      = '0;
    m_run     = 1'b0;
    m_trg     = 1'b0;
    m_prv     = '0;
    m_prv_vld = 1'b0;
    m_spre    = 0;
    m_spst    = 0;
    m_idx     = 0;
    t_issue   = '0;
    reset     = 1'b1;
    wb_req    = '0;
    sti_dat   = '0;
    sti_vld   = 1'b0;
    sto_rdy   = 1'b1;
    cts       = '0;
    trg_ext   = 2'b00;
    repeat (2) @(posedge bus);
    reset <= 1'b0;
    fd = $fopen("tests/la_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/la_tests.txt");
      seq_errs++;
    end else begin
      while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd.substr(0, 0) == "#") begin
          r = $fgets(line, fd);
        end else if (cmd == "T") begin
          end_test();
          r = $fscanf(fd, "%s", tname);
        end else if (cmd == "W") begin
          r = $fscanf(fd, "%h %h", a, d);
          if (a[`LA_AW-1:0] == `LA_ADR_CTL && d[1]) begin
            t_issue = cts;
          end
          wb_access(1'b1, a, d, rd);
          model_write(a, d);
        end else if (cmd == "R") begin
          r = $fscanf(fd, "%h %h", a, d);
          wb_access(1'b0, a, '0, rd);
          check_word($sformatf("read %h", a[7:0]), d, rd);
        end else if (cmd == "S") begin
          r = $fscanf(fd, "%d", n);
          send_smps(n);
        end else if (cmd == "P") begin
          @(posedge bus);
          bp_on <= 1'b1;
        end else if (cmd == "X") begin
          r = $fscanf(fd, "%h", d);
          @(posedge bus);
          trg_ext <= d[1:0];
          // external level is seen while armed
          if (m_run && !m_trg && m_spre >= mcfg.pre && |(d[1:0] & mcfg.tsel[3:2])) begin
            m_trg = 1'b1;
          end
        end else if (cmd == "M") begin
          check_stamps();
        end else begin
          $display("unknown command %s in vector file", cmd);
          seq_errs++;
        end
      end
      $fclose(fd);
    end
    end_test();
    $display("errors: value %0d, timeout %0d, sequence %0d", val_errs, tmo_errs, seq_errs);
    if (val_errs + tmo_errs + seq_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/la_pkg.sv
rtl/str_dec.sv
la/la_regs.sv
la/la_trigger.sv
la/la_acq.sv
la/la_top.sv
tests/la_tb.sv

//--- tests/la_tests.txt
# cmd args: W adr data | R adr expected (hex), S count (decimal), P, X ext (hex), M, T name
# P turns on sto back-pressure until the next T, X drives trg_ext, M checks timestamps
T regs
R 00 00000000
R 18 00000000
R 1c 00000000
R 20 00000000
W 08 fffffff5
R 08 00000005
W 10 12345678
R 10 00005678
W 14 abcd0004
R 14 00000004
W 40 000001a5
R 40 000000a5
W 44 ffffff3c
R 44 0000003c
W 48 0000005a
R 48 0000005a
W 4c 000000c3
R 4c 000000c3
W 50 00010002
R 50 00000002
T swt_dec0
W 00 00000001
W 08 00000002
W 10 00000003
W 14 00000004
W 50 00000000
W 00 00000002
S 3
W 00 00000008
S 10
R 00 00000004
R 18 00000003
R 1c 00000004
M
T swt_dec1
W 00 00000001
W 10 00000002
W 14 00000003
W 50 00000001
W 00 00000002
S 4
W 00 00000008
S 8
R 00 00000004
R 1c 00000003
T swt_dec3
W 00 00000001
W 10 00000002
W 14 00000002
W 50 00000003
W 00 00000002
S 8
W 00 00000008
S 12
R 00 00000004
R 18 00000002
R 1c 00000002
T pattern
W 00 00000001
W 08 00000001
W 10 00000004
W 14 00000004
W 50 00000000
W 40 00000000
W 44 00000001
W 48 00000001
W 4c 00000001
W 00 00000002
S 60
R 00 00000004
M
T ext
W 00 00000001
W 08 00000004
W 10 00000003
W 14 00000005
X 0
W 00 00000002
S 3
S 4
R 00 00000002
R 18 00000003
R 1c 00000000
X 1
S 8
X 0
R 00 00000004
R 18 00000003
R 1c 00000005
T backpressure
P
W 00 00000001
W 08 00000002
W 10 00000005
W 14 00000006
W 50 00000001
W 00 00000002
S 10
W 00 00000008
S 20
R 00 00000004
R 18 00000005
R 1c 00000006
M
T stop
W 00 00000001
W 08 00000002
W 10 00000002
W 14 00000004
W 50 00000000
W 00 00000002
S 4
W 00 00000004
R 00 00000000
R 18 00000002
R 1c 00000000
M
